//--- tb.f
common/quad_ctrl_pkg.sv
quad_ctrl/quad_job_fsm.sv
quad_ctrl/pfb_reader.sv
quad_ctrl/seq_reader.sv
verilog/quad_bram_ctrl.sv
verification/tb_quad_bram_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the quad BRAM controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_quad_bram_ctrl \
    && ./obj_dir/Vtb_quad_bram_ctrl | tee /dev/stderr | grep -Fx "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/tb_quad_bram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_quad_bram_ctrl
    import quad_ctrl_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 5;
    localparam int LFSR_SEED       = 93225;
    localparam int FETCH_ALLOWANCE = 24;
    localparam int HIST_LEN        = SEQ_READ_LATENCY + CE_EXEC_WIDTH - 1;

    //////////////////////////////////////////////////
    // Job table
    //////////////////////////////////////////////////

    // One fetch per input row and never fewer than the priming rows
    localparam int NUM_JOBS = 3;
    localparam int JOB_ROWS      [NUM_JOBS] = '{3, 5, 4};
    localparam int JOB_COLS      [NUM_JOBS] = '{2, 3, 0};
    localparam int JOB_SEED_OFS  [NUM_JOBS] = '{0, 11, 29};
    localparam int JOB_FETCHES   [NUM_JOBS] = '{4, 6, 5};
    localparam int JOB_PFB_READS [NUM_JOBS] = '{12, 24, 5};
    localparam int JOB_SEQ_READS [NUM_JOBS] = '{60, 120, 25};

    logic                     clk;
    logic                     rst;
    dim_t                     num_input_rows;
    dim_t                     num_input_cols;
    logic                     job_start;
    logic                     job_accept;
    logic                     job_fetch_request;
    logic                     job_fetch_in_progress;
    logic                     job_fetch_ack;
    logic                     job_fetch_complete;
    logic                     job_complete;
    logic                     job_complete_ack;
    pfb_count_t               pfb_full_count;
    logic                     pfb_rden;
    dim_t                     input_row;
    dim_t                     input_col;
    logic                     seq_rden;
    seq_addr_t                seq_rd_addr;
    logic [CE_EXEC_WIDTH-1:0] ce_execute;

    logic [16:0]              lfsr;
    int                       cur_job;
    int                       error_count = 0;
    int                       checks_done = 0;

    // Monitor state
    int                       fetch_count;
    int                       pfb_reads;
    int                       seq_reads;
    int                       accept_cycles;
    int                       accept_runs;
    int                       accept_len;
    int                       model_credits;
    int                       pos_row;
    int                       pos_col;
    int                       exp_addr;
    logic [HIST_LEN-1:0]      rden_hist;
    logic [CE_EXEC_WIDTH-1:0] exp_exec;
    logic                     exp_in_progress;
    logic                     prev_start;
    logic                     prev_accept;
    logic                     prev_req;
    logic                     prev_ack;
    logic                     prev_complete;
    logic                     prev_complete_ack;

    quad_bram_ctrl dut_i (
        .clk                   (clk),
        .rst                   (rst),
        .num_input_rows        (num_input_rows),
        .num_input_cols        (num_input_cols),
        .job_start             (job_start),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete          (job_complete),
        .job_complete_ack      (job_complete_ack),
        .pfb_full_count        (pfb_full_count),
        .pfb_rden              (pfb_rden),
        .input_row             (input_row),
        .input_col             (input_col),
        .seq_rden              (seq_rden),
        .seq_rd_addr           (seq_rd_addr),
        .ce_execute            (ce_execute)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR @ %0t ns: %s", $time, msg);
    endtask

    task automatic count_check(input int got, input int exp, input string what);
        checks_done++;
        if (got != exp) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic flag_check(input logic got, input logic exp, input string what);
        checks_done++;
        if (got !== exp) begin
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic dim_check(input dim_t got, input dim_t exp, input string what);
        checks_done++;
        if (got !== exp) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic seq_addr_check(input seq_addr_t got, input seq_addr_t exp, input string what);
        checks_done++;
        if (got !== exp) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic exec_check(input logic [CE_EXEC_WIDTH-1:0] got,
                              input logic [CE_EXEC_WIDTH-1:0] exp, input string what);
        checks_done++;
        if (got !== exp) begin
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // Two LFSR bits give 0 to 3 wait cycles
    task automatic draw_wait(output int cycles);
        cycles = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr   = lfsr_step(lfsr);
            cycles = (cycles << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic longint job_budget(input int rows, input int cols);
        return longint'((rows + 1) * (cols + 1) * SEQ_LEN
                        + (rows + 1 + PRIME_ROWS) * (2 * (cols + 1) + FETCH_ALLOWANCE) + 60);
    endfunction

    //////////////////////////////////////////////////
    // Fetch side of the environment
    //////////////////////////////////////////////////

    initial begin : fetch_model
        int wait_cycles;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && job_fetch_request) begin
                draw_wait(wait_cycles);
                repeat (wait_cycles) @(negedge clk);
                job_fetch_ack = 1'b1;
                @(negedge clk);
                job_fetch_ack = 1'b0;
                draw_wait(wait_cycles);
                repeat (wait_cycles) @(negedge clk);
                job_fetch_complete = 1'b1;
                @(negedge clk);
                job_fetch_complete = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Monitor sampling at the rising edge
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            accept_len      = 0;
            model_credits   = 0;
            exp_addr        = 0;
            rden_hist       = '0;
            exp_in_progress = 1'b0;
            prev_start      = 1'b0;
            prev_accept     = 1'b0;
            prev_req        = 1'b0;
            prev_ack        = 1'b0;
            prev_complete   = 1'b0;
            prev_complete_ack = 1'b0;
        end else begin
            if (job_start) begin
                fetch_count   = 0;
                pfb_reads     = 0;
                seq_reads     = 0;
                accept_cycles = 0;
                accept_runs   = 0;
                model_credits = 0;
                pos_row       = 0;
                pos_col       = 0;
            end

            // Accept window opens the cycle after the start
            if (prev_start && !job_accept) begin
                report_error("job_accept did not rise after job_start");
            end
            if (job_accept) begin
                accept_cycles++;
                accept_len++;
                if (!prev_accept) begin
                    accept_runs++;
                end
            end else if (prev_accept) begin
                count_check(accept_len, ACCEPT_HOLD, "job_accept run length");
                accept_len = 0;
            end

            // In progress from the cycle after the ack until the complete pulse
            flag_check(job_fetch_in_progress, exp_in_progress, "job_fetch_in_progress");
            if (job_fetch_request && job_fetch_ack) begin
                fetch_count++;
                exp_in_progress = 1'b1;
            end
            if (prev_req && !job_fetch_request && !prev_ack) begin
                report_error("job_fetch_request fell before its ack");
            end

            // Credit model and input position
            if (pfb_rden) begin
                pfb_reads++;
                if (model_credits == 0) begin
                    report_error("pfb_rden fired with no credit left");
                end else begin
                    model_credits--;
                end
                dim_check(input_row, dim_t'(pos_row), "input_row");
                dim_check(input_col, dim_t'(pos_col), "input_col");
                if (pos_col == JOB_COLS[cur_job]) begin
                    pos_col = 0;
                    pos_row++;
                end else begin
                    pos_col++;
                end
            end
            if (job_fetch_complete && exp_in_progress) begin
                model_credits   = int'(pfb_full_count);
                exp_in_progress = 1'b0;
            end

            if (seq_rden) begin
                seq_reads++;
                seq_addr_check(seq_rd_addr, seq_addr_t'(exp_addr), "seq_rd_addr");
                exp_addr = (exp_addr + 1) % SEQ_LEN;
            end

            // Tap k is the read from SEQ_READ_LATENCY + k cycles back
            for (int k = 0; k < CE_EXEC_WIDTH; k++) begin
                exp_exec[k] = rden_hist[SEQ_READ_LATENCY - 1 + k];
            end
            exec_check(ce_execute, exp_exec, "ce_execute");
            rden_hist = {rden_hist[HIST_LEN-2:0], seq_rden};

            if (prev_complete && !job_complete && !prev_complete_ack) begin
                report_error("job_complete fell before its ack");
            end

            prev_start        = job_start;
            prev_accept       = job_accept;
            prev_req          = job_fetch_request;
            prev_ack          = job_fetch_ack;
            prev_complete     = job_complete;
            prev_complete_ack = job_complete_ack;
        end
    end

    //////////////////////////////////////////////////
    // Job sequence
    //////////////////////////////////////////////////

    initial begin : main_seq
        int wait_cycles;
        int job_errors;
        rst              = 1'b1;
        job_start        = 1'b0;
        job_complete_ack = 1'b0;
        num_input_rows   = '0;
        num_input_cols   = '0;
        pfb_full_count   = '0;
        cur_job          = 0;
        lfsr             = 17'(LFSR_SEED);
        repeat (RESET_CYCLES) @(negedge clk);

        flag_check(job_accept, 1'b0, "job_accept in reset");
        flag_check(job_fetch_request, 1'b0, "job_fetch_request in reset");
        flag_check(job_fetch_in_progress, 1'b0, "job_fetch_in_progress in reset");
        flag_check(job_complete, 1'b0, "job_complete in reset");
        flag_check(pfb_rden, 1'b0, "pfb_rden in reset");
        flag_check(seq_rden, 1'b0, "seq_rden in reset");
        exec_check(ce_execute, '0, "ce_execute in reset");
        rst = 1'b0;

        for (int j = 0; j < NUM_JOBS; j++) begin
            job_errors = error_count;
            @(negedge clk);
            cur_job        = j;
            num_input_rows = dim_t'(JOB_ROWS[j]);
            num_input_cols = dim_t'(JOB_COLS[j]);
            pfb_full_count = pfb_count_t'(JOB_COLS[j] + 1);
            lfsr           = 17'(LFSR_SEED + JOB_SEED_OFS[j]);
            job_start      = 1'b1;
            @(negedge clk);
            job_start = 1'b0;

            while (!job_complete) begin
                @(negedge clk);
            end
            // Input position parked one row past the last
            dim_check(input_row, dim_t'(JOB_FETCHES[j]), "input_row at completion");
            dim_check(input_col, '0, "input_col at completion");

            draw_wait(wait_cycles);
            repeat (wait_cycles) @(negedge clk);
            job_complete_ack = 1'b1;
            @(negedge clk);
            job_complete_ack = 1'b0;
            repeat (CE_EXEC_WIDTH + 2) @(negedge clk);

            count_check(fetch_count, JOB_FETCHES[j], "fetch handshakes");
            count_check(pfb_reads, JOB_PFB_READS[j], "pfb_rden pulses");
            count_check(seq_reads, JOB_SEQ_READS[j], "seq_rden pulses");
            count_check(accept_runs, 1, "job_accept windows");
            count_check(accept_cycles, ACCEPT_HOLD, "job_accept cycles");
            count_check(model_credits, 0, "credits left over");
            flag_check(job_complete, 1'b0, "job_complete after ack");
            $display("job %0d (%0d x %0d): %0d fetches, %0d PFB reads, %0d seq reads, %0d errors",
                     j, JOB_ROWS[j], JOB_COLS[j], fetch_count, pfb_reads, seq_reads,
                     error_count - job_errors);
        end

        $display("%0d jobs, %0d checks, %0d errors", NUM_JOBS, checks_done, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        longint limit_cycles;
        limit_cycles = RESET_CYCLES + 10;
        for (int j = 0; j < NUM_JOBS; j++) begin
            limit_cycles += job_budget(JOB_ROWS[j], JOB_COLS[j]);
        end
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: the jobs did not finish within %0d clock cycles", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/quad_bram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module quad_bram_ctrl
    import quad_ctrl_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  dim_t                     num_input_rows,
    input  dim_t                     num_input_cols,
    input  wire                      job_start,
    output logic                     job_accept,
    output logic                     job_fetch_request,
    output logic                     job_fetch_in_progress,
    input  wire                      job_fetch_ack,
    input  wire                      job_fetch_complete,
    output logic                     job_complete,
    input  wire                      job_complete_ack,
    input  pfb_count_t               pfb_full_count,
    output logic                     pfb_rden,
    output dim_t                     input_row,
    output dim_t                     input_col,
    output logic                     seq_rden,
    output seq_addr_t                seq_rd_addr,
    output logic [CE_EXEC_WIDTH-1:0] ce_execute
);

    quad_state_t state;
    logic        credits_empty;
    logic        rows_primed;
    logic        input_done;
    logic        row_done;
    logic        last_row;

    //////////////////////////////////////////////////
    // Job control
    //////////////////////////////////////////////////

    quad_job_fsm job_fsm_i (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .credits_empty         (credits_empty),
        .rows_primed           (rows_primed),
        .input_done            (input_done),
        .row_done              (row_done),
        .last_row              (last_row),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .state                 (state)
    );

    // PFB drain
    pfb_reader pfb_reader_i (
        .clk                   (clk),
        .rst                   (rst),
        .state                 (state),
        .job_fetch_complete    (job_fetch_complete),
        .job_fetch_in_progress (job_fetch_in_progress),
        .pfb_full_count        (pfb_full_count),
        .num_input_rows        (num_input_rows),
        .num_input_cols        (num_input_cols),
        .pfb_rden              (pfb_rden),
        .credits_empty         (credits_empty),
        .rows_primed           (rows_primed),
        .input_done            (input_done),
        .input_row             (input_row),
        .input_col             (input_col)
    );

    // Sequence reads and execute strobes
    seq_reader seq_reader_i (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .num_input_rows (num_input_rows),
        .num_input_cols (num_input_cols),
        .seq_rden       (seq_rden),
        .seq_rd_addr    (seq_rd_addr),
        .ce_execute     (ce_execute),
        .row_done       (row_done),
        .last_row       (last_row)
    );

endmodule

`default_nettype wire

//--- quad_ctrl/seq_reader.sv
`timescale 1ns/1ns
`default_nettype none

module seq_reader
    import quad_ctrl_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  quad_state_t              state,
    input  dim_t                     num_input_rows,
    input  dim_t                     num_input_cols,
    output logic                     seq_rden,
    output seq_addr_t                seq_rd_addr,
    output logic [CE_EXEC_WIDTH-1:0] ce_execute,
    output logic                     row_done,
    output logic                     last_row
);

    seq_addr_t                   row_reads;
    seq_addr_t                   reads_left;
    logic [SEQ_READ_LATENCY-2:0] rd_dly;
    seq_addr_t                   exec_addr;
    dim_t                        out_col;
    dim_t                        out_row;
    logic                        pixel_end;
    logic                        row_end;

    // Reads for one output row
    assign row_reads = seq_addr_t'((32'(num_input_cols) + 1) * SEQ_LEN);

    //////////////////////////////////////////////////
    // Sequence read issue
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rden   <= 1'b0;
            reads_left <= '0;
        end else if (state == ACTIVE) begin
            seq_rden <= reads_left != '0;
            if (reads_left != '0) begin
                reads_left <= reads_left - 1'b1;
            end
        end else begin
            seq_rden   <= 1'b0;
            reads_left <= row_reads;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rd_addr <= '0;
        end else if (seq_rden) begin
            seq_rd_addr <= (seq_rd_addr == seq_addr_t'(SEQ_LEN - 1)) ? '0 : seq_rd_addr + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // BRAM latency and execute taps
    //////////////////////////////////////////////////

    // Two delay stages plus the tap 0 register
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly     <= '0;
            ce_execute <= '0;
        end else begin
            rd_dly     <= {rd_dly[SEQ_READ_LATENCY-3:0], seq_rden};
            ce_execute <= {ce_execute[CE_EXEC_WIDTH-2:0], rd_dly[SEQ_READ_LATENCY-2]};
        end
    end

    // Output pixel position, counted from executed cycles
    assign pixel_end = ce_execute[0] && exec_addr == seq_addr_t'(SEQ_LEN - 1);
    assign row_end   = pixel_end && out_col == num_input_cols;
    assign row_done  = row_end && out_row != num_input_rows;
    assign last_row  = row_end && out_row == num_input_rows;

    always_ff @(posedge clk) begin
        if (rst || state == IDLE) begin
            exec_addr <= '0;
            out_col   <= '0;
            out_row   <= '0;
        end else if (ce_execute[0]) begin
            exec_addr <= pixel_end ? '0 : exec_addr + 1'b1;
            if (row_end) begin
                out_col <= '0;
                out_row <= out_row + 1'b1;
            end else if (pixel_end) begin
                out_col <= out_col + 1'b1;
            end
        end
    end

    a_seq_addr_range: assert property (@(posedge clk) disable iff (rst)
        seq_rd_addr < SEQ_LEN);

endmodule

`default_nettype wire

//--- quad_ctrl/pfb_reader.sv
`timescale 1ns/1ns
`default_nettype none

module pfb_reader
    import quad_ctrl_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  quad_state_t state,
    input  wire         job_fetch_complete,
    input  wire         job_fetch_in_progress,
    input  pfb_count_t  pfb_full_count,
    input  dim_t        num_input_rows,
    input  dim_t        num_input_cols,
    output logic        pfb_rden,
    output logic        credits_empty,
    output logic        rows_primed,
    output logic        input_done,
    output dim_t        input_row,
    output dim_t        input_col
);

    pfb_count_t credits;
    pfb_count_t credits_left;
    logic       read_phase;
    logic       rden_next;

    // A read already on pfb_rden has taken its credit
    assign credits_left  = credits - pfb_count_t'(pfb_rden);
    assign read_phase    = (state == PRIME && !rows_primed) || state == FIN_ROW;
    assign rden_next     = read_phase && credits_left != '0;

    assign credits_empty = credits == '0;
    assign rows_primed   = input_row == dim_t'(PRIME_ROWS - 1) && credits == pfb_full_count;
    assign input_done    = input_row > num_input_rows;

    //////////////////////////////////////////////////
    // Credit counter and read strobe
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            credits  <= '0;
            pfb_rden <= 1'b0;
        end else begin
            pfb_rden <= rden_next;
            if (state == IDLE) begin
                credits <= '0;
            end else if (job_fetch_complete && job_fetch_in_progress) begin
                credits <= pfb_full_count;
            end else begin
                credits <= credits_left;
            end
        end
    end

    // Input position follows the reads
    always_ff @(posedge clk) begin
        if (rst || state == IDLE) begin
            input_row <= '0;
            input_col <= '0;
        end else if (pfb_rden) begin
            if (input_col == num_input_cols) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

    a_read_has_credit: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> credits != '0);

endmodule

`default_nettype wire

//--- quad_ctrl/quad_job_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module quad_job_fsm
    import quad_ctrl_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         job_start,
    input  wire         job_fetch_ack,
    input  wire         job_fetch_complete,
    input  wire         job_complete_ack,
    input  wire         credits_empty,
    input  wire         rows_primed,
    input  wire         input_done,
    input  wire         row_done,
    input  wire         last_row,
    output logic        job_accept,
    output logic        job_fetch_request,
    output logic        job_fetch_in_progress,
    output logic        job_complete,
    output quad_state_t state
);

    // Phase to resume once the PFB load finishes
    quad_state_t            ret_state;
    logic [ACCEPT_HOLD-1:0] accept_sr;
    logic                   fetch_acked;
    logic                   complete_acked;

    //////////////////////////////////////////////////
    // Job accept window
    //////////////////////////////////////////////////

    assign job_accept = |accept_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            accept_sr <= '0;
        end else begin
            accept_sr <= {accept_sr[ACCEPT_HOLD-2:0], (state == IDLE) && job_start};
        end
    end

    //////////////////////////////////////////////////
    // Phase sequencing and handshakes
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state                 <= IDLE;
            ret_state             <= IDLE;
            job_fetch_request     <= 1'b0;
            job_fetch_in_progress <= 1'b0;
            fetch_acked           <= 1'b0;
            job_complete          <= 1'b0;
            complete_acked        <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (job_start) begin
                        state <= PRIME;
                    end
                end
                PRIME: begin
                    // Read out each loaded row, refetch until four rows sit in the PFB
                    if (rows_primed) begin
                        state <= ACTIVE;
                    end else if (credits_empty) begin
                        ret_state <= PRIME;
                        state     <= WAIT_LOAD;
                    end
                end
                WAIT_LOAD: begin
                    if (job_fetch_request && job_fetch_ack) begin
                        job_fetch_request     <= 1'b0;
                        job_fetch_in_progress <= 1'b1;
                        fetch_acked           <= 1'b1;
                    end else if (!fetch_acked) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (job_fetch_in_progress && job_fetch_complete) begin
                        job_fetch_in_progress <= 1'b0;
                        fetch_acked           <= 1'b0;
                        state                 <= ret_state;
                    end
                end
                ACTIVE: begin
                    if (last_row) begin
                        state <= DONE;
                    end else if (row_done) begin
                        state <= FIN_ROW;
                    end
                end
                FIN_ROW: begin
                    // Drain the buffered row, then pull the next one if the map has more
                    if (credits_empty) begin
                        if (!input_done) begin
                            ret_state <= ACTIVE;
                            state     <= WAIT_LOAD;
                        end else begin
                            state <= ACTIVE;
                        end
                    end
                end
                DONE: begin
                    if (complete_acked) begin
                        complete_acked <= 1'b0;
                        state          <= IDLE;
                    end else if (job_complete && job_complete_ack) begin
                        job_complete   <= 1'b0;
                        complete_acked <= 1'b1;
                    end else begin
                        job_complete <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, PRIME, WAIT_LOAD, ACTIVE, FIN_ROW, DONE});

    // A fetch in flight pins the phase to the load wait
    a_fetch_in_load: assert property (@(posedge clk) disable iff (rst)
        job_fetch_in_progress |-> state == WAIT_LOAD);

endmodule

`default_nettype wire

//--- common/quad_ctrl_pkg.sv
`default_nettype none

package quad_ctrl_pkg;

    //////////////////////////////////////////////////
    // Map dimensions and PFB credits
    //////////////////////////////////////////////////

    // BRAM depth of 1024, less one bit
    localparam int DIM_WIDTH = 9;
    typedef logic [DIM_WIDTH-1:0] dim_t;

    localparam int PFB_COUNT_WIDTH = 9;
    typedef logic [PFB_COUNT_WIDTH-1:0] pfb_count_t;

    //////////////////////////////////////////////////
    // Sequence memory
    //////////////////////////////////////////////////

    // Reads per output pixel
    localparam int SEQ_LEN = 5;

    localparam int SEQ_ADDR_WIDTH = 12;
    typedef logic [SEQ_ADDR_WIDTH-1:0] seq_addr_t;

    // Sequence BRAM read to first execute strobe
    localparam int SEQ_READ_LATENCY = 3;

    //////////////////////////////////////////////////
    // Job control
    //////////////////////////////////////////////////

    localparam int PRIME_ROWS  = 4;
    localparam int ACCEPT_HOLD = 5;

    localparam int NUM_AWE        = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int CE_EXEC_WIDTH  = NUM_AWE * NUM_CE_PER_AWE;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        PRIME     = 3'd1,
        WAIT_LOAD = 3'd2,
        ACTIVE    = 3'd3,
        FIN_ROW   = 3'd4,
        DONE      = 3'd5
    } quad_state_t;

endpackage

`default_nettype wire
